// ==== Makefile ====
# Verilator build and run for the background layer testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_background
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= test passed

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run fails unless the pass line shows up in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+src
src/ppu_bg_pkg.sv
src/ppu_bg_scan_counter.sv
src/ppu_bg_fetch_fsm.sv
src/ppu_bg_addr_gen.sv
src/ppu_bg_pixel_shifter.sv
src/ppu_background.sv
tb/bg_memory_model.sv
tb/tb_ppu_background.sv

// ==== src/ppu_background.sv ====
`include "ppu_bg_settings.svh"

module ppu_background (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  logic [`BG_W_COORD-1:0]       beam_x,
	input  logic [`BG_W_COORD-1:0]       beam_y,
	output logic                         bus_vld,
	output logic [`BG_W_ADDR-1:0]        bus_addr,
	output logic [1:0]                   bus_size,
	input  logic                         bus_rdy,
	input  logic [`BG_W_DATA-1:0]        bus_data,
	input  logic [`BG_W_COORD-1:0]       cfg_scroll_x,
	input  logic [`BG_W_COORD-1:0]       cfg_scroll_y,
	input  logic [`BG_W_LOG_COORD-1:0]   cfg_log_w,
	input  logic [`BG_W_LOG_COORD-1:0]   cfg_log_h,
	input  logic [`BG_W_ADDR-1:0]        cfg_tileset_base,
	input  logic [`BG_W_ADDR-1:0]        cfg_tilemap_base,
	input  logic                         cfg_tile_size,
	input  ppu_bg_pkg::pixel_mode_t      cfg_pixel_mode,
	input  logic                         cfg_transparency,
	output logic                         out_vld,
	input  logic                         out_rdy,
	output logic [`BG_W_OUTDATA-1:0]     out_pixdata,
	output logic                         out_alpha,
	output logic                         out_paletted
);

	logic [`BG_W_COORD-1:0] u;
	logic [`BG_W_COORD-1:0] v;
	logic                   next_tile_edge;
	logic                   next_word_edge;
	logic                   pix_step;
	logic                   tile_phase;
	logic                   tile_load;
	logic                   word_load;
	logic                   addr_hold;

	// --------------------------------------------------
	// Position and fetch control

	ppu_bg_scan_counter i_scan_counter (
		.clk(clk), .rst_n(rst_n), .flush(flush), .pix_step(pix_step),
		.beam_x(beam_x), .beam_y(beam_y),
		.cfg_scroll_x(cfg_scroll_x), .cfg_scroll_y(cfg_scroll_y),
		.cfg_log_w(cfg_log_w), .cfg_log_h(cfg_log_h),
		.cfg_tile_size(cfg_tile_size), .cfg_pixel_mode(cfg_pixel_mode),
		.u(u), .v(v), .next_tile_edge(next_tile_edge), .next_word_edge(next_word_edge)
	);

	ppu_bg_fetch_fsm i_fetch_fsm (
		.clk(clk), .rst_n(rst_n), .flush(flush), .bus_rdy(bus_rdy), .out_rdy(out_rdy),
		.next_tile_edge(next_tile_edge), .next_word_edge(next_word_edge),
		.bus_vld(bus_vld), .tile_phase(tile_phase), .tile_load(tile_load),
		.word_load(word_load), .out_vld(out_vld), .pix_step(pix_step),
		.addr_hold(addr_hold)
	);

	// --------------------------------------------------
	// Datapath

	ppu_bg_addr_gen i_addr_gen (
		.clk(clk), .rst_n(rst_n), .tile_load(tile_load), .tile_phase(tile_phase),
		.addr_hold(addr_hold), .bus_data(bus_data), .u(u), .v(v),
		.cfg_log_w(cfg_log_w), .cfg_tile_size(cfg_tile_size),
		.cfg_pixel_mode(cfg_pixel_mode), .cfg_tileset_base(cfg_tileset_base),
		.cfg_tilemap_base(cfg_tilemap_base), .bus_addr(bus_addr), .bus_size(bus_size)
	);

	ppu_bg_pixel_shifter i_pixel_shifter (
		.clk(clk), .rst_n(rst_n), .word_load(word_load), .bus_data(bus_data),
		.u(u), .v(v), .cfg_tile_size(cfg_tile_size), .cfg_pixel_mode(cfg_pixel_mode),
		.cfg_transparency(cfg_transparency), .out_pixdata(out_pixdata),
		.out_alpha(out_alpha), .out_paletted(out_paletted)
	);

endmodule

// ==== src/ppu_bg_addr_gen.sv ====
`include "ppu_bg_settings.svh"

module ppu_bg_addr_gen (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         tile_load,
	input  logic                         tile_phase,
	input  logic                         addr_hold,
	input  logic [`BG_W_DATA-1:0]        bus_data,
	input  logic [`BG_W_COORD-1:0]       u,
	input  logic [`BG_W_COORD-1:0]       v,
	input  logic [`BG_W_LOG_COORD-1:0]   cfg_log_w,
	input  logic                         cfg_tile_size,
	input  ppu_bg_pkg::pixel_mode_t      cfg_pixel_mode,
	input  logic [`BG_W_ADDR-1:0]        cfg_tileset_base,
	input  logic [`BG_W_ADDR-1:0]        cfg_tilemap_base,
	output logic [`BG_W_ADDR-1:0]        bus_addr,
	output logic [1:0]                   bus_size
);

	logic [`BG_W_TILENUM-1:0] tile_num;
	logic [`BG_W_ADDR-1:0]    addr_q;
	logic [1:0]               size_q;
	logic [`BG_W_ADDR-1:0]    u_ext;
	logic [`BG_W_ADDR-1:0]    v_ext;
	logic [`BG_W_ADDR-1:0]    map_row;
	logic [`BG_W_ADDR-1:0]    map_col;
	logic [`BG_W_ADDR-1:0]    pix_idx;
	logic [`BG_W_ADDR-1:0]    bit_addr;
	logic [`BG_W_ADDR-1:0]    set_addr;

	assign u_ext = {{(`BG_W_ADDR-`BG_W_COORD){1'b0}}, u};
	assign v_ext = {{(`BG_W_ADDR-`BG_W_COORD){1'b0}}, v};

	// --------------------------------------------------
	// Tilemap entry: one byte per tile, 2^log_w/T entries per row
	assign map_col = cfg_tile_size ? (u_ext >> 4) : (u_ext >> 3);
	assign map_row = cfg_tile_size ? (((v_ext >> 4) << cfg_log_w) >> 4) :
		(((v_ext >> 3) << cfg_log_w) >> 3);

	// --------------------------------------------------
	// Tileset word: tiles packed back to back, rows of T pixels each
	assign pix_idx = cfg_tile_size ?
		{{(`BG_W_ADDR-`BG_W_TILENUM-8){1'b0}}, tile_num, v[3:0], u[3:0]} :
		{{(`BG_W_ADDR-`BG_W_TILENUM-6){1'b0}}, tile_num, v[2:0], u[2:0]};
	assign bit_addr = pix_idx << cfg_pixel_mode;
	// Bit address to an aligned byte address of the enclosing word
	assign set_addr = cfg_tileset_base + {3'b000, bit_addr[`BG_W_ADDR-1:5], 2'b00};

	// During a drain the stale request must keep its address and size
	assign bus_addr = addr_hold ? addr_q :
		(tile_phase ? cfg_tilemap_base + map_row + map_col : set_addr);
	assign bus_size = addr_hold ? size_q : (tile_phase ? 2'd0 : 2'd2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tile_num <= '0;
			addr_q <= '0;
			size_q <= 2'd0;
		end else begin
			addr_q <= bus_addr;
			size_q <= bus_size;
			if (tile_load)
				tile_num <= bus_data[`BG_W_TILENUM-1:0];
		end
	end

endmodule

// ==== src/ppu_bg_fetch_fsm.sv ====
module ppu_bg_fetch_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  logic bus_rdy,
	input  logic out_rdy,
	input  logic next_tile_edge,
	input  logic next_word_edge,
	output logic bus_vld,
	output logic tile_phase,
	output logic tile_load,
	output logic word_load,
	output logic out_vld,
	output logic pix_step,
	output logic addr_hold
);

	ppu_bg_pkg::fetch_state_t state;
	ppu_bg_pkg::fetch_state_t state_next;

	// --------------------------------------------------
	// Moore outputs

	// A request stays up through a drain until the memory answers
	assign bus_vld = (state == ppu_bg_pkg::ST_TILE_REQ) ||
		(state == ppu_bg_pkg::ST_PIX_REQ) ||
		(state == ppu_bg_pkg::ST_DRAIN);
	assign tile_phase = (state == ppu_bg_pkg::ST_TILE_REQ);
	assign addr_hold = (state == ppu_bg_pkg::ST_DRAIN);
	assign out_vld = (state == ppu_bg_pkg::ST_EMIT);
	assign pix_step = out_vld && out_rdy;

	// Data that arrives together with a flush belongs to the old position
	assign tile_load = (state == ppu_bg_pkg::ST_TILE_REQ) && bus_rdy && !flush;
	assign word_load = (state == ppu_bg_pkg::ST_PIX_REQ) && bus_rdy && !flush;

	// --------------------------------------------------
	// Next state

	always_comb begin
		state_next = state;
		if (flush) begin
			// An unanswered request has to be completed and thrown away first
			if (bus_vld && !bus_rdy)
				state_next = ppu_bg_pkg::ST_DRAIN;
			else
				state_next = ppu_bg_pkg::ST_TILE_REQ;
		end else begin
			unique case (state)
				ppu_bg_pkg::ST_TILE_REQ: begin
					if (bus_rdy)
						state_next = ppu_bg_pkg::ST_PIX_REQ;
				end
				ppu_bg_pkg::ST_PIX_REQ: begin
					if (bus_rdy)
						state_next = ppu_bg_pkg::ST_EMIT;
				end
				ppu_bg_pkg::ST_EMIT: begin
					// Tile edge first, since a new tile also needs a new word
					if (out_rdy) begin
						if (next_tile_edge)
							state_next = ppu_bg_pkg::ST_TILE_REQ;
						else if (next_word_edge)
							state_next = ppu_bg_pkg::ST_PIX_REQ;
					end
				end
				ppu_bg_pkg::ST_DRAIN: begin
					if (bus_rdy)
						state_next = ppu_bg_pkg::ST_TILE_REQ;
				end
				default: begin
					state_next = ppu_bg_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ppu_bg_pkg::ST_IDLE;
		else
			state <= state_next;
	end

endmodule

// ==== src/ppu_bg_pixel_shifter.sv ====
`include "ppu_bg_settings.svh"

module ppu_bg_pixel_shifter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         word_load,
	input  logic [`BG_W_DATA-1:0]        bus_data,
	input  logic [`BG_W_COORD-1:0]       u,
	input  logic [`BG_W_COORD-1:0]       v,
	input  logic                         cfg_tile_size,
	input  ppu_bg_pkg::pixel_mode_t      cfg_pixel_mode,
	input  logic                         cfg_transparency,
	output logic [`BG_W_OUTDATA-1:0]     out_pixdata,
	output logic                         out_alpha,
	output logic                         out_paletted
);

	logic [`BG_W_DATA-1:0] pix_word;
	logic [7:0]            tile_offs;
	logic [4:0]            bit_offs;
	logic [`BG_W_DATA-1:0] shifted;
	logic [7:0]            pal_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pix_word <= '0;
		else if (word_load)
			pix_word <= bus_data;
	end

	// Small rows share a word, so the row inside the tile matters as well as u
	assign tile_offs = cfg_tile_size ? {v[3:0], u[3:0]} : {2'b00, v[2:0], u[2:0]};
	// Tiles start on word boundaries; only the low bits of the offset count
	assign bit_offs = tile_offs[4:0] << cfg_pixel_mode;
	assign shifted = pix_word >> bit_offs;

	// --------------------------------------------------
	// Pixel select and format

	always_comb begin
		unique case (cfg_pixel_mode)
			ppu_bg_pkg::PM_PAL1: pal_idx = {7'h00, shifted[0]};
			ppu_bg_pkg::PM_PAL2: pal_idx = {6'h00, shifted[1:0]};
			ppu_bg_pkg::PM_PAL4: pal_idx = {4'h0, shifted[3:0]};
			default:             pal_idx = shifted[7:0];
		endcase
	end

	always_comb begin
		if (cfg_pixel_mode == ppu_bg_pkg::PM_ARGB16) begin
			// Direct colour carries its own alpha in the top bit
			out_pixdata = shifted[14:0];
			out_alpha = shifted[15];
			out_paletted = 1'b0;
		end else begin
			out_pixdata = {{(`BG_W_OUTDATA-8){1'b0}}, pal_idx};
			out_alpha = !(cfg_transparency && (pal_idx == 8'h00));
			out_paletted = 1'b1;
		end
	end

endmodule

// ==== src/ppu_bg_pkg.sv ====
package ppu_bg_pkg;

	// Fetch sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_TILE_REQ,
		ST_PIX_REQ,
		ST_EMIT,
		ST_DRAIN
	} fetch_state_t;

	// Pixel formats, encoded as log2 of the bits per pixel
	typedef enum logic [2:0] {
		PM_PAL1   = 3'd0,
		PM_PAL2   = 3'd1,
		PM_PAL4   = 3'd2,
		PM_PAL8   = 3'd3,
		PM_ARGB16 = 3'd4
	} pixel_mode_t;

endpackage

// ==== src/ppu_bg_scan_counter.sv ====
`include "ppu_bg_settings.svh"

module ppu_bg_scan_counter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  logic                         pix_step,
	input  logic [`BG_W_COORD-1:0]       beam_x,
	input  logic [`BG_W_COORD-1:0]       beam_y,
	input  logic [`BG_W_COORD-1:0]       cfg_scroll_x,
	input  logic [`BG_W_COORD-1:0]       cfg_scroll_y,
	input  logic [`BG_W_LOG_COORD-1:0]   cfg_log_w,
	input  logic [`BG_W_LOG_COORD-1:0]   cfg_log_h,
	input  logic                         cfg_tile_size,
	input  ppu_bg_pkg::pixel_mode_t      cfg_pixel_mode,
	output logic [`BG_W_COORD-1:0]       u,
	output logic [`BG_W_COORD-1:0]       v,
	output logic                         next_tile_edge,
	output logic                         next_word_edge
);

	// Layer size masks, all ones once the log size reaches the coordinate width
	logic [`BG_W_COORD-1:0] w_mask;
	logic [`BG_W_COORD-1:0] h_mask;
	logic [`BG_W_COORD-1:0] u_next;
	logic [4:0]             next_bit_offs;

	assign w_mask = ~({`BG_W_COORD{1'b1}} << cfg_log_w);
	assign h_mask = ~({`BG_W_COORD{1'b1}} << cfg_log_h);
	assign u_next = (u + 1'b1) & w_mask;

	// A wrap of u lands on zero, so the low tile bits cover that case too
	assign next_tile_edge = cfg_tile_size ? (u_next[3:0] == 4'h0) : (u_next[2:0] == 3'h0);

	// Only the low five bits of u*b decide the bit position inside a word
	assign next_bit_offs = u_next[4:0] << cfg_pixel_mode;
	assign next_word_edge = (next_bit_offs == 5'h0);

	// Flush takes priority over a pixel step in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u <= '0;
			v <= '0;
		end else if (flush) begin
			u <= (beam_x + cfg_scroll_x) & w_mask;
			v <= (beam_y + cfg_scroll_y) & h_mask;
		end else if (pix_step) begin
			u <= u_next;
		end
	end

endmodule

// ==== src/ppu_bg_settings.svh ====
`ifndef PPU_BG_SETTINGS_SVH
`define PPU_BG_SETTINGS_SVH

// Beam, scroll and background coordinate width
`define BG_W_COORD 10
// Width of the log2 layer size fields
`define BG_W_LOG_COORD 4

// Memory bus
`define BG_W_ADDR 32
`define BG_W_DATA 32

// Output pixel stream and tilemap entry
`define BG_W_OUTDATA 15
`define BG_W_TILENUM 8

`endif

// ==== tb/bg_memory_model.sv ====
`include "ppu_bg_settings.svh"

module bg_memory_model (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  bus_vld,
	input  logic [`BG_W_ADDR-1:0] bus_addr,
	input  logic [1:0]            bus_size,
	input  logic [1:0]            wait_sel,
	output logic                  bus_rdy,
	output logic [`BG_W_DATA-1:0] bus_data,
	output logic                  hold_error
);
	timeunit 1ns;
	timeprecision 1ps;

	logic                  busy;
	logic [1:0]            wait_left;
	logic [`BG_W_ADDR-1:0] req_addr;
	logic [1:0]            req_size;

	// Top byte of an odd multiply depends on every address bit
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] h;
		h = a * 32'h9e3779b1;
		return h[31:24] ^ h[15:8];
	endfunction

	// Byte reads return in bits 7:0, word reads are little-endian
	function automatic logic [31:0] read_bus(input logic [31:0] a, input logic [1:0] size);
		if (size == 2'd0)
			return {24'h000000, mem_byte(a)};
		return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
	endfunction

	// --------------------------------------------------
	// Request handling with 0 to 3 wait states per request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_rdy <= 1'b0;
			bus_data <= '0;
			busy <= 1'b0;
			wait_left <= 2'd0;
			req_addr <= '0;
			req_size <= 2'd0;
			hold_error <= 1'b0;
		end else begin
			bus_rdy <= 1'b0;
			// A request answered in this cycle is done, the next one starts fresh
			if (bus_vld && !bus_rdy) begin
				if (busy && (bus_addr != req_addr || bus_size != req_size))
					hold_error <= 1'b1;
				if (!busy && wait_sel != 2'd0) begin
					busy <= 1'b1;
					wait_left <= wait_sel - 2'd1;
					req_addr <= bus_addr;
					req_size <= bus_size;
				end else if (!busy || wait_left == 2'd0) begin
					busy <= 1'b0;
					bus_rdy <= 1'b1;
					bus_data <= read_bus(bus_addr, bus_size);
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule

// ==== tb/tb_ppu_background.sv ====
`include "ppu_bg_settings.svh"

module tb_ppu_background;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS = 10;
	localparam logic [31:0] MAP_BASE = 32'h0000_1000;
	localparam logic [31:0] SET_BASE = 32'h0002_0000;

	// One row of the stimulus table
	typedef struct packed {
		logic [`BG_W_COORD-1:0]     scroll_x;
		logic [`BG_W_COORD-1:0]     scroll_y;
		logic [`BG_W_COORD-1:0]     beam_x;
		logic [`BG_W_COORD-1:0]     beam_y;
		logic [`BG_W_LOG_COORD-1:0] log_w;
		logic [`BG_W_LOG_COORD-1:0] log_h;
		logic                       tile_size;
		ppu_bg_pkg::pixel_mode_t    mode;
		logic                       transp;
		logic [9:0]                 count;
		logic                       abort;
	} test_row_t;

	logic                         clk;
	logic                         rst_n;
	logic                         flush;
	logic [`BG_W_COORD-1:0]       beam_x;
	logic [`BG_W_COORD-1:0]       beam_y;
	logic                         bus_vld;
	logic [`BG_W_ADDR-1:0]        bus_addr;
	logic [1:0]                   bus_size;
	logic                         bus_rdy;
	logic [`BG_W_DATA-1:0]        bus_data;
	logic [`BG_W_COORD-1:0]       cfg_scroll_x;
	logic [`BG_W_COORD-1:0]       cfg_scroll_y;
	logic [`BG_W_LOG_COORD-1:0]   cfg_log_w;
	logic [`BG_W_LOG_COORD-1:0]   cfg_log_h;
	logic [`BG_W_ADDR-1:0]        cfg_tileset_base;
	logic [`BG_W_ADDR-1:0]        cfg_tilemap_base;
	logic                         cfg_tile_size;
	ppu_bg_pkg::pixel_mode_t      cfg_pixel_mode;
	logic                         cfg_transparency;
	logic                         out_vld;
	logic                         out_rdy;
	logic [`BG_W_OUTDATA-1:0]     out_pixdata;
	logic                         out_alpha;
	logic                         out_paletted;
	logic [1:0]                   wait_sel;
	logic                         hold_error;

	test_row_t   rows [NUM_TESTS];
	string       names [NUM_TESTS];
	int          num_rows;
	int          errors;
	int          failing_tests;
	int          checked;
	int          cycles;
	logic        take_en;
	logic        slow_mem;
	logic [31:0] lfsr_state;

	ppu_background i_dut (.*);
	bg_memory_model i_memory (.*);

	always #50 clk = ~clk;

	// --------------------------------------------------
	// Helpers
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		// Galois form with taps 32 22 2 1
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// Same contents formula as the memory model
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] h;
		h = a * 32'h9e3779b1;
		return h[31:24] ^ h[15:8];
	endfunction

	// Reference pixel as {paletted, alpha, pixdata} from the layout rules
	function automatic logic [16:0] expected_pixel(input test_row_t r, input int u, input int v);
		int          t;
		int          b;
		int          tile;
		int          bit_addr;
		int          word_addr;
		logic [31:0] word;
		logic [15:0] pix;
		logic        alpha;
		t = r.tile_size ? 16 : 8;
		b = 1 << int'(r.mode);
		tile = int'(mem_byte(32'(int'(MAP_BASE) + (v / t) * ((1 << int'(r.log_w)) / t) + u / t)));
		bit_addr = (tile * t * t + (v % t) * t + (u % t)) * b;
		word_addr = int'(SET_BASE) + (bit_addr / 32) * 4;
		word = {mem_byte(32'(word_addr + 3)), mem_byte(32'(word_addr + 2)),
			mem_byte(32'(word_addr + 1)), mem_byte(32'(word_addr))};
		pix = 16'((word >> (bit_addr % 32)) & 32'((1 << b) - 1));
		if (r.mode == ppu_bg_pkg::PM_ARGB16)
			return {1'b0, pix[15], pix[14:0]};
		alpha = !(r.transp && pix == 16'h0000);
		return {1'b1, alpha, pix[14:0]};
	endfunction

	function automatic int cycle_limit();
		int total;
		total = 0;
		for (int i = 0; i < num_rows; i++)
			total += int'(rows[i].count);
		return total * 24 + 200;
	endfunction

	task automatic add_row(input string name, input int sx, input int sy, input int bx,
		input int by, input int lw, input int lh, input bit ts,
		input ppu_bg_pkg::pixel_mode_t mode, input bit tr, input int count, input bit abort);
		names[num_rows] = name;
		rows[num_rows].scroll_x = `BG_W_COORD'(sx);
		rows[num_rows].scroll_y = `BG_W_COORD'(sy);
		rows[num_rows].beam_x = `BG_W_COORD'(bx);
		rows[num_rows].beam_y = `BG_W_COORD'(by);
		rows[num_rows].log_w = `BG_W_LOG_COORD'(lw);
		rows[num_rows].log_h = `BG_W_LOG_COORD'(lh);
		rows[num_rows].tile_size = ts;
		rows[num_rows].mode = mode;
		rows[num_rows].transp = tr;
		rows[num_rows].count = 10'(count);
		rows[num_rows].abort = abort;
		num_rows++;
	endtask

	// Wait until the DUT sits in its emit state with out_rdy held low
	task automatic wait_parked();
		do @(negedge clk); while (!out_vld);
	endtask

	task automatic run_row(input int row);
		test_row_t   r;
		int          u0;
		int          v0;
		int          taken;
		int          bad;
		logic [16:0] want;
		logic [16:0] got;
		r = rows[row];
		taken = 0;
		bad = 0;
		u0 = (int'(r.beam_x) + int'(r.scroll_x)) % (1 << int'(r.log_w));
		v0 = (int'(r.beam_y) + int'(r.scroll_y)) % (1 << int'(r.log_h));
		if (row > 0)
			wait_parked();
		// Long wait states keep the decoy word request open across the re-flush
		slow_mem = r.abort;
		@(posedge clk);
		cfg_scroll_x <= r.scroll_x;
		cfg_scroll_y <= r.scroll_y;
		cfg_log_w <= r.log_w;
		cfg_log_h <= r.log_h;
		cfg_tile_size <= r.tile_size;
		cfg_pixel_mode <= r.mode;
		cfg_transparency <= r.transp;
		// Abort rows start at a decoy position that the second flush replaces
		beam_x <= r.abort ? r.beam_x + `BG_W_COORD'(37) : r.beam_x;
		beam_y <= r.abort ? r.beam_y + `BG_W_COORD'(19) : r.beam_y;
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		if (r.abort) begin
			// Re-flush while the first pixel word request is still out
			do @(negedge clk); while (!(bus_vld && bus_size == 2'd2));
			@(posedge clk);
			beam_x <= r.beam_x;
			beam_y <= r.beam_y;
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
			slow_mem = 1'b0;
			@(negedge clk);
			// The stale word request must still be open and draining here
			assert (bus_vld && bus_size == 2'd2) else begin
				$display("%s: the re-flush found no pending pixel fetch to drain",
					names[row]);
				bad++;
			end
		end
		@(negedge clk);
		take_en = 1'b1;
		while (taken < int'(r.count)) begin
			@(negedge clk);
			if (out_vld && out_rdy) begin
				want = expected_pixel(r, (u0 + taken) % (1 << int'(r.log_w)), v0);
				got = {out_paletted, out_alpha, out_pixdata};
				assert (got == want) else begin
					$display("MISMATCH %s pixel %0d: expected %h, actual %h",
						names[row], taken, want, got);
					bad++;
				end
				taken++;
				if (taken == int'(r.count))
					take_en = 1'b0;
			end
		end
		checked += taken;
		errors += bad;
		if (bad != 0)
			failing_tests++;
		$display("%s: %0d pixels, %0d mismatches", names[row], taken, bad);
	endtask

	// --------------------------------------------------
	// Random out_rdy and wait states, one LFSR step per bit
	always @(posedge clk) begin : draw_random
		logic       rdy_bit;
		logic [1:0] wait_bits;
		rdy_bit = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		wait_bits[1] = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		wait_bits[0] = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		out_rdy <= take_en && rdy_bit;
		wait_sel <= slow_mem ? 2'd3 : wait_bits;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit()) begin
			$display("Timeout: the pixel stream stalled past %0d cycles", cycle_limit());
			$display("test failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		lfsr_state = 32'hef25ee34;
		take_en = 1'b0;
		slow_mem = 1'b0;
		num_rows = 0;
		errors = 0;
		failing_tests = 0;
		checked = 0;
		cycles = 0;
		rst_n <= 1'b0;
		flush <= 1'b0;
		beam_x <= '0;
		beam_y <= '0;
		out_rdy <= 1'b0;
		wait_sel <= 2'd0;
		cfg_scroll_x <= '0;
		cfg_scroll_y <= '0;
		cfg_log_w <= `BG_W_LOG_COORD'(6);
		cfg_log_h <= `BG_W_LOG_COORD'(6);
		cfg_tileset_base <= SET_BASE;
		cfg_tilemap_base <= MAP_BASE;
		cfg_tile_size <= 1'b0;
		cfg_pixel_mode <= ppu_bg_pkg::PM_PAL1;
		cfg_transparency <= 1'b0;
		// name, scroll x/y, beam x/y, log w/h, tile 16, mode, transp, pixels, abort
		add_row("pal1_8x8", 3, 5, 10, 20, 6, 6, 0, ppu_bg_pkg::PM_PAL1, 0, 40, 0);
		add_row("pal2_8x8", 0, 0, 4, 9, 7, 5, 0, ppu_bg_pkg::PM_PAL2, 0, 40, 0);
		add_row("pal4_8x8", 17, 2, 1, 33, 6, 7, 0, ppu_bg_pkg::PM_PAL4, 0, 40, 0);
		add_row("pal8_8x8", 0, 12, 6, 3, 7, 6, 0, ppu_bg_pkg::PM_PAL8, 0, 40, 0);
		add_row("argb16_16x16", 5, 0, 20, 40, 8, 7, 1, ppu_bg_pkg::PM_ARGB16, 0, 48, 0);
		add_row("scroll_wrap", 1000, 100, 20, 7, 5, 4, 0, ppu_bg_pkg::PM_PAL4, 0, 48, 0);
		add_row("transp_pal1", 2, 2, 0, 1, 6, 6, 0, ppu_bg_pkg::PM_PAL1, 1, 40, 0);
		add_row("transp_pal2_16", 9, 3, 30, 50, 7, 6, 1, ppu_bg_pkg::PM_PAL2, 1, 40, 0);
		add_row("abort_pal8_16", 7, 1, 60, 22, 8, 8, 1, ppu_bg_pkg::PM_PAL8, 0, 32, 1);
		add_row("abort_pal4", 0, 0, 3, 3, 6, 6, 0, ppu_bg_pkg::PM_PAL4, 1, 32, 1);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (int row = 0; row < num_rows; row++)
			run_row(row);
		assert (!hold_error) else begin
			$display("A bus request changed its address or size while waiting for rdy");
			errors++;
		end
		$display("%0d tests, %0d failing, %0d pixels checked, %0d errors",
			num_rows, failing_tests, checked, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
